//--- dv/ifu_dec_checker.sv
`timescale 1ns/10ps

module ifu_dec_checker
   import dec_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input alu_bundle_t alu_e,
   input lsu_bundle_t lsu_e,
   input bru_bundle_t bru_e,
   input exc_bundle_t exc_e
);

   // one unit per slot
   a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({lsu_e.valid, bru_e.valid, alu_e.wen}))
      else $error("more than one execution unit got the same slot");

   // a faulting slot dispatches nothing
   a_exc_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      exc_e.exception |-> !(lsu_e.valid || lsu_e.wen || bru_e.valid || alu_e.wen))
      else $error("exception slot also set a dispatch bit");

   // control held low in reset
   a_reset_low: assert property (@(posedge clk)
      !rst_n |-> !(lsu_e.valid || lsu_e.wen || bru_e.valid || alu_e.wen || exc_e.exception))
      else $error("control bit high during reset");

endmodule

bind ifu_dec ifu_dec_checker u_checker (
   .clk   (clk),
   .rst_n (rst_n),
   .alu_e (alu_e),
   .lsu_e (lsu_e),
   .bru_e (bru_e),
   .exc_e (exc_e)
);

//--- dv/tb_ifu_dec.sv
`timescale 1ns/10ps

module tb_ifu_dec
   import isa_pkg::*, dec_pkg::*;
();

   localparam int max_cycles = 2000;

   typedef enum logic [4:0] {
      k_add, k_sub, k_and, k_or, k_xor, k_addi, k_ori, k_lu12i, k_pcadd,
      k_ld, k_st, k_beq, k_bne, k_b, k_bl, k_sys, k_brk, k_ill
   } kind_e;

   typedef enum logic [1:0] {cls_alu, cls_lsu, cls_bru, cls_exc} cls_e;

   logic        clk = 1'b0;
   logic        rst_n;
   word_t       inst;
   word_t       pc;
   logic        inst_vld;
   word_t       rs1_data;
   word_t       rs2_data;
   reg_idx_t    rs1_d;
   reg_idx_t    rs2_d;
   alu_bundle_t alu_e;
   lsu_bundle_t lsu_e;
   bru_bundle_t bru_e;
   exc_bundle_t exc_e;
   reg_idx_t    rf_target_e;
   reg_idx_t    rs1_e;
   reg_idx_t    rs2_e;

   // expected e-stage view of the slot in flight
   logic        p_vld;
   cls_e        p_cls;
   alu_bundle_t p_alu;
   lsu_bundle_t p_lsu;
   bru_bundle_t p_bru;
   exc_bundle_t p_exc;
   reg_idx_t    p_tgt;
   reg_idx_t    p_rs1;
   reg_idx_t    p_rs2;

   int err_cnt   = 0;
   int slot_cnt  = 0;
   int cycle_cnt = 0;

   ifu_dec dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .inst        (inst),
      .pc          (pc),
      .inst_vld    (inst_vld),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .rs1_d       (rs1_d),
      .rs2_d       (rs2_d),
      .alu_e       (alu_e),
      .lsu_e       (lsu_e),
      .bru_e       (bru_e),
      .exc_e       (exc_e),
      .rf_target_e (rf_target_e),
      .rs1_e       (rs1_e),
      .rs2_e       (rs2_e)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////
   // instruction model

   // standard loongarch32 encodings with all fields zero
   function automatic word_t base_word(input kind_e k);
      case (k)
         k_add:   return 32'h0010_0000;
         k_sub:   return 32'h0011_0000;
         k_and:   return 32'h0014_8000;
         k_or:    return 32'h0015_0000;
         k_xor:   return 32'h0015_8000;
         k_addi:  return 32'h0280_0000;
         k_ori:   return 32'h0380_0000;
         k_lu12i: return 32'h1400_0000;
         k_pcadd: return 32'h1c00_0000;
         k_ld:    return 32'h2880_0000;
         k_st:    return 32'h2980_0000;
         k_beq:   return 32'h5800_0000;
         k_bne:   return 32'h5c00_0000;
         k_b:     return 32'h5000_0000;
         k_bl:    return 32'h5400_0000;
         k_sys:   return 32'h002b_0000;
         k_brk:   return 32'h002a_0000;
         default: return 32'h0000_0000;
      endcase
   endfunction

   function automatic word_t encode(input kind_e k, input reg_idx_t rd, input reg_idx_t rj,
                                    input reg_idx_t rk, input word_t imm);
      word_t w;
      w = base_word(k);
      case (k)
         k_addi, k_ori, k_ld, k_st: w = w | {10'd0, imm[11:0], rj, rd};
         k_lu12i, k_pcadd:          w = w | {7'd0, imm[19:0], rd};
         k_beq, k_bne:              w = w | {6'd0, imm[15:0], rj, rd};
         k_b, k_bl:                 w = w | {6'd0, imm[15:0], imm[25:16]};
         k_sys, k_brk:              w = w | {17'd0, imm[14:0]};
         k_ill:                     w = imm;
         default:                   w = w | {17'd0, rk, rj, rd};
      endcase
      return w;
   endfunction

   task automatic mismatch(input string name, input word_t exp, input word_t act);
      err_cnt++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
   endtask

   // e-stage outputs against the slot driven one cycle earlier
   task automatic check_prev();
      if (alu_e.wen !== p_alu.wen)
         mismatch("alu_e.wen", 32'(p_alu.wen), 32'(alu_e.wen));
      if (lsu_e.valid !== p_lsu.valid)
         mismatch("lsu_e.valid", 32'(p_lsu.valid), 32'(lsu_e.valid));
      if (lsu_e.wen !== p_lsu.wen)
         mismatch("lsu_e.wen", 32'(p_lsu.wen), 32'(lsu_e.wen));
      if (bru_e.valid !== p_bru.valid)
         mismatch("bru_e.valid", 32'(p_bru.valid), 32'(bru_e.valid));
      if (exc_e.exception !== p_exc.exception)
         mismatch("exc_e.exception", 32'(p_exc.exception), 32'(exc_e.exception));
      if (p_vld) begin
         if (rs1_e !== p_rs1)
            mismatch("rs1_e", 32'(p_rs1), 32'(rs1_e));
         if (rs2_e !== p_rs2)
            mismatch("rs2_e", 32'(p_rs2), 32'(rs2_e));
         case (p_cls)
            cls_alu: begin
               if (alu_e.a !== p_alu.a)
                  mismatch("alu_e.a", p_alu.a, alu_e.a);
               if (alu_e.b !== p_alu.b)
                  mismatch("alu_e.b", p_alu.b, alu_e.b);
               if (alu_e.op !== p_alu.op)
                  mismatch("alu_e.op", 32'(p_alu.op), 32'(alu_e.op));
               if (alu_e.b_imm !== p_alu.b_imm)
                  mismatch("alu_e.b_imm", 32'(p_alu.b_imm), 32'(alu_e.b_imm));
               if (rf_target_e !== p_tgt)
                  mismatch("rf_target_e", 32'(p_tgt), 32'(rf_target_e));
            end
            cls_lsu: begin
               if (lsu_e.op !== p_lsu.op)
                  mismatch("lsu_e.op", 32'(p_lsu.op), 32'(lsu_e.op));
               if (lsu_e.rd !== p_lsu.rd)
                  mismatch("lsu_e.rd", 32'(p_lsu.rd), 32'(lsu_e.rd));
               if (lsu_e.imm !== p_lsu.imm)
                  mismatch("lsu_e.imm", p_lsu.imm, lsu_e.imm);
            end
            cls_bru: begin
               if (bru_e.op !== p_bru.op)
                  mismatch("bru_e.op", 32'(p_bru.op), 32'(bru_e.op));
               if (bru_e.offset !== p_bru.offset)
                  mismatch("bru_e.offset", p_bru.offset, bru_e.offset);
               if (rf_target_e !== p_tgt)
                  mismatch("rf_target_e", 32'(p_tgt), 32'(rf_target_e));
            end
            default: begin
               if (exc_e.exccode !== p_exc.exccode)
                  mismatch("exc_e.exccode", 32'(p_exc.exccode), 32'(exc_e.exccode));
            end
         endcase
      end
   endtask

   // drives one decode slot on the rising edge and checks it on the falling edge
   task automatic issue(input logic vld, input kind_e k, input word_t imm);
      word_t       w;
      word_t       pcv;
      word_t       d1;
      word_t       d2;
      word_t       si12;
      logic        rd_read;
      cls_e        n_cls;
      alu_bundle_t n_alu;
      lsu_bundle_t n_lsu;
      bru_bundle_t n_bru;
      exc_bundle_t n_exc;
      w       = encode(k, 5'($urandom()), 5'($urandom()), 5'($urandom()), imm);
      pcv     = $urandom() & 32'hffff_fffc;
      d1      = $urandom();
      d2      = $urandom();
      si12    = {{20{imm[11]}}, imm[11:0]};
      rd_read = (k == k_st) || (k == k_beq) || (k == k_bne);
      n_alu   = '0;
      n_lsu   = '0;
      n_bru   = '0;
      n_exc   = '0;
      case (k)
         k_ld, k_st: begin
            n_cls       = cls_lsu;
            n_lsu.valid = vld;
            n_lsu.op    = (k == k_st) ? lsu_store : lsu_load;
            n_lsu.wen   = vld & (k == k_ld);
            n_lsu.rd    = w[4:0];
            n_lsu.imm   = si12;
         end
         k_beq, k_bne, k_b, k_bl: begin
            n_cls       = cls_bru;
            n_bru.valid = vld;
            case (k)
               k_beq:   n_bru.op = bru_beq;
               k_bne:   n_bru.op = bru_bne;
               k_b:     n_bru.op = bru_b;
               default: n_bru.op = bru_bl;
            endcase
            if (k == k_beq || k == k_bne) begin
               n_bru.offset = {{14{imm[15]}}, imm[15:0], 2'b00};
            end else begin
               n_bru.offset = {{4{imm[25]}}, imm[25:0], 2'b00};
            end
         end
         k_sys, k_brk, k_ill: begin
            n_cls           = cls_exc;
            n_exc.exception = vld;
            n_exc.exccode   = (k == k_sys) ? 6'd11 : (k == k_brk) ? 6'd12 : 6'd13;
         end
         default: begin
            n_cls       = cls_alu;
            n_alu.wen   = vld;
            n_alu.a     = (k == k_pcadd) ? pcv : d1;
            n_alu.b_imm = (k == k_addi) || (k == k_ori) || (k == k_lu12i) || (k == k_pcadd);
            case (k)
               k_addi:           n_alu.b = si12;
               k_ori:            n_alu.b = {20'd0, imm[11:0]};
               k_lu12i, k_pcadd: n_alu.b = {imm[19:0], 12'd0};
               default:          n_alu.b = d2;
            endcase
            case (k)
               k_sub:       n_alu.op = alu_sub;
               k_and:       n_alu.op = alu_and;
               k_or, k_ori: n_alu.op = alu_or;
               k_xor:       n_alu.op = alu_xor;
               k_lu12i:     n_alu.op = alu_pass_b;
               default:     n_alu.op = alu_add;
            endcase
         end
      endcase

      @(posedge clk);
      inst     <= w;
      pc       <= pcv;
      inst_vld <= vld;
      rs1_data <= d1;
      rs2_data <= d2;
      @(negedge clk);
      // source indices in the same cycle
      if (vld && rs1_d !== w[9:5])
         mismatch("rs1_d", 32'(w[9:5]), 32'(rs1_d));
      if (vld && rs2_d !== (rd_read ? w[4:0] : w[14:10]))
         mismatch("rs2_d", 32'(rd_read ? w[4:0] : w[14:10]), 32'(rs2_d));
      check_prev();
      p_vld = vld;
      p_cls = n_cls;
      p_alu = n_alu;
      p_lsu = n_lsu;
      p_bru = n_bru;
      p_exc = n_exc;
      p_tgt = (k == k_bl) ? 5'd1 : w[4:0];
      p_rs1 = w[9:5];
      p_rs2 = rd_read ? w[4:0] : w[14:10];
      slot_cnt++;
   endtask

   ////////////////////
   // directed tests

   task automatic test_alu();
      repeat (20) issue(1'b1, kind_e'($urandom_range(4, 0)), 32'h0);
      repeat (10) issue(1'b1, k_addi, $urandom());
      repeat (10) issue(1'b1, k_ori, $urandom());
      issue(1'b0, k_add, 32'h0);
   endtask

   task automatic test_upper_imm();
      issue(1'b1, k_lu12i, 32'h000f_ffff);
      issue(1'b1, k_lu12i, 32'h0008_0000);
      issue(1'b1, k_pcadd, 32'h0000_0001);
      issue(1'b1, k_ori, 32'h0000_0800);
      issue(1'b1, k_addi, 32'h0000_0800);
      repeat (8) issue(1'b1, $urandom_range(1, 0) ? k_lu12i : k_pcadd, $urandom());
      issue(1'b0, k_add, 32'h0);
   endtask

   task automatic test_lsu();
      issue(1'b1, k_ld, 32'h0000_07ff);
      issue(1'b1, k_st, 32'h0000_0800);
      repeat (12) issue(1'b1, $urandom_range(1, 0) ? k_ld : k_st, $urandom());
      issue(1'b0, k_add, 32'h0);
   endtask

   task automatic test_branch();
      issue(1'b1, k_beq, 32'h0000_8000);
      issue(1'b1, k_bne, 32'h0000_7fff);
      issue(1'b1, k_b, 32'h0200_0000);
      issue(1'b1, k_bl, 32'h03ff_ffff);
      repeat (12) issue(1'b1, kind_e'($urandom_range(14, 11)), $urandom());
      issue(1'b0, k_add, 32'h0);
   endtask

   task automatic test_exceptions();
      issue(1'b1, k_sys, $urandom());
      issue(1'b1, k_brk, $urandom());
      issue(1'b1, k_ill, 32'h0000_0000);
      issue(1'b1, k_add, 32'h0);
      issue(1'b1, k_ill, 32'hffff_ffff);
      issue(1'b0, k_sys, 32'h0);
      issue(1'b0, k_add, 32'h0);
   endtask

   // random kinds with random empty slots
   task automatic test_stream();
      repeat (80) issue(1'($urandom_range(1, 0)), kind_e'($urandom_range(16, 0)), $urandom());
      issue(1'b0, k_add, 32'h0);
   endtask

   initial begin
      void'($urandom(60953));
      rst_n    <= 1'b0;
      inst     <= '0;
      pc       <= '0;
      inst_vld <= 1'b0;
      rs1_data <= '0;
      rs2_data <= '0;
      // first check expects an idle stage
      p_vld = 1'b0;
      p_cls = cls_alu;
      p_alu = '0;
      p_lsu = '0;
      p_bru = '0;
      p_exc = '0;
      p_tgt = '0;
      p_rs1 = '0;
      p_rs2 = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      // reset values before the first capture
      @(negedge clk);
      check_prev();

      test_alu();
      test_upper_imm();
      test_lsu();
      test_branch();
      test_exceptions();
      test_stream();

      $display("%0d slots checked, %0d errors", slot_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- flist.f
source/isa_pkg.sv
source/dec_pkg.sv
source/dec_opcode.sv
source/dec_imm.sv
source/dec_dispatch.sv
source/dec_d2e_reg.sv
source/ifu_dec.sv
dv/ifu_dec_checker.sv
dv/tb_ifu_dec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module tb_ifu_dec -Mdir "$obj" -f flist.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$obj/Vtb_ifu_dec" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
   exit 0
else
   exit 1
fi

//--- source/dec_d2e_reg.sv
`timescale 1ns/10ps

module dec_d2e_reg
   import isa_pkg::*, dec_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  alu_bundle_t alu_d,
   input  lsu_bundle_t lsu_d,
   input  bru_bundle_t bru_d,
   input  exc_bundle_t exc_d,
   input  reg_idx_t    rf_target_d,
   input  reg_idx_t    rs1_d,
   input  reg_idx_t    rs2_d,
   output alu_bundle_t alu_e,
   output lsu_bundle_t lsu_e,
   output bru_bundle_t bru_e,
   output exc_bundle_t exc_e,
   output reg_idx_t    rf_target_e,
   output reg_idx_t    rs1_e,
   output reg_idx_t    rs2_e
);

   // control
   logic alu_wen_q;
   logic lsu_vld_q;
   logic lsu_wen_q;
   logic bru_vld_q;
   logic exc_q;

   // payload
   word_t    alu_a_q;
   word_t    alu_b_q;
   alu_op_e  alu_op_q;
   logic     alu_b_imm_q;
   lsu_op_e  lsu_op_q;
   reg_idx_t lsu_rd_q;
   word_t    lsu_imm_q;
   bru_op_e  bru_op_q;
   word_t    bru_offs_q;
   exccode_t exccode_q;
   reg_idx_t rf_target_q;
   reg_idx_t rs1_q;
   reg_idx_t rs2_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         alu_wen_q <= 1'b0;
         lsu_vld_q <= 1'b0;
         lsu_wen_q <= 1'b0;
         bru_vld_q <= 1'b0;
         exc_q     <= 1'b0;
      end else begin
         alu_wen_q <= alu_d.wen;
         lsu_vld_q <= lsu_d.valid;
         lsu_wen_q <= lsu_d.wen;
         bru_vld_q <= bru_d.valid;
         exc_q     <= exc_d.exception;
      end
   end

   always_ff @(posedge clk) begin
      alu_a_q     <= alu_d.a;
      alu_b_q     <= alu_d.b;
      alu_op_q    <= alu_d.op;
      alu_b_imm_q <= alu_d.b_imm;
      lsu_op_q    <= lsu_d.op;
      lsu_rd_q    <= lsu_d.rd;
      lsu_imm_q   <= lsu_d.imm;
      bru_op_q    <= bru_d.op;
      bru_offs_q  <= bru_d.offset;
      exccode_q   <= exc_d.exccode;
      rf_target_q <= rf_target_d;
      rs1_q       <= rs1_d;
      rs2_q       <= rs2_d;
   end

   ////////////////////
   // e-stage bundles

   assign alu_e = '{wen: alu_wen_q, a: alu_a_q, b: alu_b_q, op: alu_op_q, b_imm: alu_b_imm_q};
   assign lsu_e = '{valid: lsu_vld_q, op: lsu_op_q, wen: lsu_wen_q, rd: lsu_rd_q,
                    imm: lsu_imm_q};
   assign bru_e = '{valid: bru_vld_q, op: bru_op_q, offset: bru_offs_q};
   assign exc_e = '{exception: exc_q, exccode: exccode_q};

   assign rf_target_e = rf_target_q;
   assign rs1_e       = rs1_q;
   assign rs2_e       = rs2_q;

endmodule

//--- source/dec_dispatch.sv
`timescale 1ns/10ps

module dec_dispatch
   import isa_pkg::*, dec_pkg::*;
(
   input  inst_u       inst,
   input  word_t       pc,
   input  logic        inst_vld,
   input  dec_res_t    res,
   input  word_t       imm,
   input  word_t       br_offs,
   input  word_t       rs1_data,
   input  word_t       rs2_data,
   output reg_idx_t    rs1_d,
   output reg_idx_t    rs2_d,
   output reg_idx_t    rf_target_d,
   output alu_bundle_t alu_d,
   output lsu_bundle_t lsu_d,
   output bru_bundle_t bru_d,
   output exc_bundle_t exc_d
);

   logic exc_any;
   logic issue;
   logic alu_go;
   logic lsu_go;
   logic bru_go;
   logic b_imm;

   ////////////////////
   // exceptions

   assign exc_any = res.syscall | res.brk | res.ine;

   assign exc_d.exception = inst_vld & exc_any;

   // syscall wins over break and break over ine
   always_comb begin
      if (res.syscall) begin
         exc_d.exccode = exc_sys;
      end else if (res.brk) begin
         exc_d.exccode = exc_brk;
      end else if (res.ine) begin
         exc_d.exccode = exc_ine;
      end else begin
         exc_d.exccode = '0;
      end
   end

   ////////////////////
   // unit select

   // nothing dispatches on an empty slot or a faulting word
   assign issue  = inst_vld & ~exc_any;
   assign alu_go = issue & (res.unit == unit_alu);
   assign lsu_go = issue & (res.unit == unit_lsu);
   assign bru_go = issue & (res.unit == unit_bru);

   // register indices
   assign rs1_d = inst.fmt_3r.rj;
   assign rs2_d = res.rd_read ? inst.fmt_3r.rd : inst.fmt_3r.rk;

   assign rf_target_d = (res.unit == unit_bru && res.bru_op == bru_bl) ?
                        ra_idx : inst.fmt_3r.rd;

   ////////////////////
   // alu operands

   assign b_imm = (res.imm_kind != imm_none) & alu_go;

   assign alu_d.wen   = alu_go & res.gr_wen;
   assign alu_d.a     = res.pc_rel ? pc : rs1_data;
   assign alu_d.b     = b_imm ? imm : rs2_data;
   assign alu_d.op    = res.alu_op;
   assign alu_d.b_imm = b_imm;

   // lsu
   assign lsu_d.valid = lsu_go;
   assign lsu_d.op    = res.lsu_op;
   assign lsu_d.wen   = lsu_go & res.gr_wen;
   assign lsu_d.rd    = rf_target_d;
   assign lsu_d.imm   = imm;

   // bru
   assign bru_d.valid  = bru_go;
   assign bru_d.op     = res.bru_op;
   assign bru_d.offset = br_offs;

endmodule

//--- source/dec_imm.sv
`timescale 1ns/10ps

module dec_imm
   import isa_pkg::*, dec_pkg::*;
(
   input  inst_u    inst,
   input  dec_res_t res,
   output word_t    imm,
   output word_t    br_offs
);

   logic [11:0] imm12;
   logic [19:0] imm20;
   logic [15:0] offs16;
   logic [9:0]  offs_hi;

   assign imm12   = inst.fmt_2ri12.imm12;
   assign imm20   = inst.fmt_1ri20.imm20;
   assign offs16  = inst.fmt_i26.offs16;
   // b/bl keep the upper offset bits in the rj/rd slots
   assign offs_hi = {inst.fmt_i26.rj, inst.fmt_i26.rd};

   // alu and lsu immediate
   always_comb begin
      case (res.imm_kind)
         imm_si12:    imm = {{20{imm12[11]}}, imm12};
         imm_ui12:    imm = {20'd0, imm12};
         imm_si20_hi: imm = {imm20, 12'd0};
         default:     imm = '0;
      endcase
   end

   // branch offset, word aligned
   always_comb begin
      case (res.imm_kind)
         imm_offs16: br_offs = {{14{offs16[15]}}, offs16, 2'b00};
         imm_offs26: br_offs = {{4{offs_hi[9]}}, offs_hi, offs16, 2'b00};
         default:    br_offs = '0;
      endcase
   end

endmodule

//--- source/dec_opcode.sv
`timescale 1ns/10ps

module dec_opcode
   import isa_pkg::*, dec_pkg::*;
(
   input  inst_u    inst,
   output dec_res_t res
);

   always_comb begin
      // default is an alu add with no write and no immediate
      res = '0;

      ////////////////////
      // 3r register-register and traps
      if (inst.fmt_3r.op == op_add_w) begin
         res.alu_op = alu_add;
         res.gr_wen = 1'b1;
      end else if (inst.fmt_3r.op == op_sub_w) begin
         res.alu_op = alu_sub;
         res.gr_wen = 1'b1;
      end else if (inst.fmt_3r.op == op_and) begin
         res.alu_op = alu_and;
         res.gr_wen = 1'b1;
      end else if (inst.fmt_3r.op == op_or) begin
         res.alu_op = alu_or;
         res.gr_wen = 1'b1;
      end else if (inst.fmt_3r.op == op_xor) begin
         res.alu_op = alu_xor;
         res.gr_wen = 1'b1;
      end else if (inst.fmt_3r.op == op_syscall) begin
         res.syscall = 1'b1;
      end else if (inst.fmt_3r.op == op_break) begin
         res.brk = 1'b1;

      ////////////////////
      // 2ri12 alu and memory
      end else if (inst.fmt_2ri12.op == op_addi_w) begin
         res.alu_op   = alu_add;
         res.imm_kind = imm_si12;
         res.gr_wen   = 1'b1;
      end else if (inst.fmt_2ri12.op == op_ori) begin
         res.alu_op   = alu_or;
         res.imm_kind = imm_ui12;
         res.gr_wen   = 1'b1;
      end else if (inst.fmt_2ri12.op == op_ld_w) begin
         res.unit     = unit_lsu;
         res.lsu_op   = lsu_load;
         res.imm_kind = imm_si12;
         res.gr_wen   = 1'b1;
      end else if (inst.fmt_2ri12.op == op_st_w) begin
         res.unit     = unit_lsu;
         res.lsu_op   = lsu_store;
         res.imm_kind = imm_si12;
         res.rd_read  = 1'b1;   // store data comes from rd

      ////////////////////
      // 1ri20 upper immediates
      end else if (inst.fmt_1ri20.op == op_lu12i_w) begin
         res.alu_op   = alu_pass_b;
         res.imm_kind = imm_si20_hi;
         res.gr_wen   = 1'b1;
      end else if (inst.fmt_1ri20.op == op_pcaddu12i) begin
         res.alu_op   = alu_add;
         res.imm_kind = imm_si20_hi;
         res.pc_rel   = 1'b1;
         res.gr_wen   = 1'b1;

      ////////////////////
      // branches
      end else if (inst.fmt_i26.op == op_beq) begin
         res.unit     = unit_bru;
         res.bru_op   = bru_beq;
         res.imm_kind = imm_offs16;
         res.rd_read  = 1'b1;
      end else if (inst.fmt_i26.op == op_bne) begin
         res.unit     = unit_bru;
         res.bru_op   = bru_bne;
         res.imm_kind = imm_offs16;
         res.rd_read  = 1'b1;
      end else if (inst.fmt_i26.op == op_b) begin
         res.unit     = unit_bru;
         res.bru_op   = bru_b;
         res.imm_kind = imm_offs26;
      end else if (inst.fmt_i26.op == op_bl) begin
         res.unit     = unit_bru;
         res.bru_op   = bru_bl;
         res.imm_kind = imm_offs26;
         res.gr_wen   = 1'b1;   // link write to r1
      end else begin
         // outside the supported subset
         res.ine = 1'b1;
      end
   end

endmodule

//--- source/dec_pkg.sv
package dec_pkg;

   import isa_pkg::*;

   ////////////////////
   // unit and operation codes

   typedef enum logic [1:0] {
      unit_alu = 2'd0,
      unit_lsu = 2'd1,
      unit_bru = 2'd2
   } unit_e;

   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_pass_b = 3'd5
   } alu_op_e;

   typedef enum logic {
      lsu_load  = 1'b0,
      lsu_store = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      bru_beq = 2'd0,
      bru_bne = 2'd1,
      bru_b   = 2'd2,
      bru_bl  = 2'd3
   } bru_op_e;

   typedef enum logic [2:0] {
      imm_none    = 3'd0,
      imm_si12    = 3'd1,
      imm_ui12    = 3'd2,
      imm_si20_hi = 3'd3,
      imm_offs16  = 3'd4,
      imm_offs26  = 3'd5
   } imm_kind_e;

   ////////////////////
   // decode result

   typedef struct packed {
      unit_e     unit;
      alu_op_e   alu_op;
      lsu_op_e   lsu_op;
      bru_op_e   bru_op;
      imm_kind_e imm_kind;
      logic      gr_wen;
      logic      rd_read;   // second source is rd
      logic      pc_rel;
      logic      syscall;
      logic      brk;
      logic      ine;
   } dec_res_t;

   ////////////////////
   // execute-stage bundles

   typedef struct packed {
      logic    wen;
      word_t   a;
      word_t   b;
      alu_op_e op;
      logic    b_imm;
   } alu_bundle_t;

   typedef struct packed {
      logic     valid;
      lsu_op_e  op;
      logic     wen;
      reg_idx_t rd;
      word_t    imm;
   } lsu_bundle_t;

   typedef struct packed {
      logic    valid;
      bru_op_e op;
      word_t   offset;
   } bru_bundle_t;

   typedef struct packed {
      logic     exception;
      exccode_t exccode;
   } exc_bundle_t;

endpackage

//--- source/ifu_dec.sv
`timescale 1ns/10ps

module ifu_dec
   import isa_pkg::*, dec_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  word_t       inst,
   input  word_t       pc,
   input  logic        inst_vld,
   input  word_t       rs1_data,
   input  word_t       rs2_data,
   output reg_idx_t    rs1_d,
   output reg_idx_t    rs2_d,
   output alu_bundle_t alu_e,
   output lsu_bundle_t lsu_e,
   output bru_bundle_t bru_e,
   output exc_bundle_t exc_e,
   output reg_idx_t    rf_target_e,
   output reg_idx_t    rs1_e,
   output reg_idx_t    rs2_e
);

   dec_res_t    res;
   word_t       imm;
   word_t       br_offs;
   reg_idx_t    rf_target_d;
   alu_bundle_t alu_d;
   lsu_bundle_t lsu_d;
   bru_bundle_t bru_d;
   exc_bundle_t exc_d;

   ////////////////////
   // decode stage

   dec_opcode u_opcode (
      .inst (inst),
      .res  (res)
   );

   dec_imm u_imm (
      .inst    (inst),
      .res     (res),
      .imm     (imm),
      .br_offs (br_offs)
   );

   dec_dispatch u_dispatch (
      .inst        (inst),
      .pc          (pc),
      .inst_vld    (inst_vld),
      .res         (res),
      .imm         (imm),
      .br_offs     (br_offs),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .rs1_d       (rs1_d),
      .rs2_d       (rs2_d),
      .rf_target_d (rf_target_d),
      .alu_d       (alu_d),
      .lsu_d       (lsu_d),
      .bru_d       (bru_d),
      .exc_d       (exc_d)
   );

   // d to e boundary
   dec_d2e_reg u_d2e (
      .clk         (clk),
      .rst_n       (rst_n),
      .alu_d       (alu_d),
      .lsu_d       (lsu_d),
      .bru_d       (bru_d),
      .exc_d       (exc_d),
      .rf_target_d (rf_target_d),
      .rs1_d       (rs1_d),
      .rs2_d       (rs2_d),
      .alu_e       (alu_e),
      .lsu_e       (lsu_e),
      .bru_e       (bru_e),
      .exc_e       (exc_e),
      .rf_target_e (rf_target_e),
      .rs1_e       (rs1_e),
      .rs2_e       (rs2_e)
   );

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [5:0]  exccode_t;

   ////////////////////
   // instruction formats

   typedef struct packed {
      logic [16:0] op;
      reg_idx_t    rk;
      reg_idx_t    rj;
      reg_idx_t    rd;
   } fmt_3r_t;

   typedef struct packed {
      logic [9:0]  op;
      logic [11:0] imm12;
      reg_idx_t    rj;
      reg_idx_t    rd;
   } fmt_2ri12_t;

   typedef struct packed {
      logic [6:0]  op;
      logic [19:0] imm20;
      reg_idx_t    rd;
   } fmt_1ri20_t;

   // b and bl keep offs[25:16] where beq/bne keep rj and rd
   typedef struct packed {
      logic [5:0]  op;
      logic [15:0] offs16;
      reg_idx_t    rj;
      reg_idx_t    rd;
   } fmt_i26_t;

   typedef union packed {
      fmt_3r_t    fmt_3r;
      fmt_2ri12_t fmt_2ri12;
      fmt_1ri20_t fmt_1ri20;
      fmt_i26_t   fmt_i26;
   } inst_u;

   ////////////////////
   // major opcodes

   localparam logic [16:0] op_add_w     = 17'h00020;
   localparam logic [16:0] op_sub_w     = 17'h00022;
   localparam logic [16:0] op_and       = 17'h00029;
   localparam logic [16:0] op_or        = 17'h0002a;
   localparam logic [16:0] op_xor       = 17'h0002b;
   localparam logic [16:0] op_break     = 17'h00054;
   localparam logic [16:0] op_syscall   = 17'h00056;
   localparam logic [9:0]  op_addi_w    = 10'h00a;
   localparam logic [9:0]  op_ori       = 10'h00e;
   localparam logic [9:0]  op_ld_w      = 10'h0a2;
   localparam logic [9:0]  op_st_w      = 10'h0a6;
   localparam logic [6:0]  op_lu12i_w   = 7'h0a;
   localparam logic [6:0]  op_pcaddu12i = 7'h0e;
   localparam logic [5:0]  op_b         = 6'h14;
   localparam logic [5:0]  op_bl        = 6'h15;
   localparam logic [5:0]  op_beq       = 6'h16;
   localparam logic [5:0]  op_bne       = 6'h17;

   // exception codes raised in decode
   localparam exccode_t exc_sys = 6'd11;
   localparam exccode_t exc_brk = 6'd12;
   localparam exccode_t exc_ine = 6'd13;

   // link register for bl
   localparam reg_idx_t ra_idx = 5'd1;

endpackage
